//--- Bender.yml
package:
  name: twdl_stage

sources:
  - design/twdl_pkg.sv
  - design/twdl_phase_counter.sv
  - design/twdl_phase_divider.sv
  - design/twdl_coeff_gen.sv
  - design/twdl_lane_multiplier.sv
  - design/twdl_stage.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_twdl_stage.sv

//--- build.f
design/twdl_pkg.sv
design/twdl_phase_counter.sv
design/twdl_phase_divider.sv
design/twdl_coeff_gen.sv
design/twdl_lane_multiplier.sv
design/twdl_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_twdl_stage.sv

//--- design/twdl_coeff_gen.sv
`timescale 1ns/100ps

module twdl_coeff_gen import twdl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  tw_index_t idx,
	output tw_coef_t  coef [NUM_LANES],
	output logic      coef_val
);

	localparam int                 N_POINTS = 1 << W_PHASE;
	localparam logic [W_PHASE-1:0] QUARTER  = W_PHASE'(N_POINTS / 4);

	logic [W_PHASE-1:0]       phase [NUM_LANES];
	logic [W_PHASE-1:0]       val_sr;
	logic signed [W_COEF-1:0] cos_rom [N_POINTS];

	// cosine table, constant after elaboration
	for (genvar p = 0; p < N_POINTS; p++) begin : g_rom
		assign cos_rom[p] = cos_q14(W_PHASE'(p));
	end

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		twdl_phase_divider i_div (
			.clk   (clk),
			.rst_n (rst_n),
			.num   (idx.num[i]),
			.den   (idx.den),
			.phase (phase[i])
		);

		// -sin(x) is -cos(x - quarter turn)
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				coef[i] <= '0;
			end else begin
				coef[i].re <= cos_rom[phase[i]];
				coef[i].im <= -cos_rom[phase[i] - QUARTER];
			end
		end
	end

	// valid follows the divider depth, then the table register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_sr   <= '0;
			coef_val <= 1'b0;
		end else begin
			val_sr   <= {val_sr[W_PHASE-2:0], idx.valid};
			coef_val <= val_sr[W_PHASE-1];
		end
	end

endmodule

//--- design/twdl_lane_multiplier.sv
`timescale 1ns/100ps

module twdl_lane_multiplier import twdl_pkg::*; #(
	parameter int W_DATA = 30,
	parameter int DELAY  = 10
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic signed [W_DATA-1:0] din_real,
	input  logic signed [W_DATA-1:0] din_imag,
	input  tw_coef_t                 coef,
	output logic signed [W_DATA-1:0] dout_real,
	output logic signed [W_DATA-1:0] dout_imag
);

	// full precision, one guard bit for the sum
	localparam int W_PROD = W_DATA + W_COEF + 1;

	logic signed [W_DATA-1:0] re_dly [DELAY];
	logic signed [W_DATA-1:0] im_dly [DELAY];
	logic signed [W_PROD-1:0] prod_re;
	logic signed [W_PROD-1:0] prod_im;

	// hold the sample until its coefficient arrives
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int j = 0; j < DELAY; j++) begin
				re_dly[j] <= '0;
				im_dly[j] <= '0;
			end
		end else begin
			re_dly[0] <= din_real;
			im_dly[0] <= din_imag;
			for (int j = 1; j < DELAY; j++) begin
				re_dly[j] <= re_dly[j-1];
				im_dly[j] <= im_dly[j-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prod_re <= '0;
			prod_im <= '0;
		end else begin
			prod_re <= re_dly[DELAY-1] * coef.re - im_dly[DELAY-1] * coef.im;
			prod_im <= re_dly[DELAY-1] * coef.im + im_dly[DELAY-1] * coef.re;
		end
	end

	// drop Q14 fraction, round half up, wrap on overflow
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dout_real <= '0;
			dout_imag <= '0;
		end else begin
			dout_real <= prod_re[W_DATA+COEF_FRAC-1 -: W_DATA] + W_DATA'(prod_re[COEF_FRAC-1]);
			dout_imag <= prod_im[W_DATA+COEF_FRAC-1 -: W_DATA] + W_DATA'(prod_im[COEF_FRAC-1]);
		end
	end

endmodule

//--- design/twdl_phase_counter.sv
`timescale 1ns/100ps

module twdl_phase_counter import twdl_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_val,
	input  logic            sof,
	input  radix_e          radix,
	input  logic [W_TW-1:0] den,
	output tw_index_t       idx
);

	// per lane (i*k) mod den
	logic [W_TW-1:0]                acc [NUM_LANES];
	radix_e                         radix_q;
	logic [W_TW-1:0]                den_q;
	radix_e                         radix_cur;
	logic [W_TW-1:0]                den_cur;
	logic [NUM_LANES-1:0][W_TW-1:0] num_cur;

	// add the lane step, wrap once at den
	function automatic logic [W_TW-1:0] next_acc(input logic [W_TW-1:0] a, input int step,
			input logic [W_TW-1:0] d);
		logic [W_TW:0] sum;
		sum = {1'b0, a} + (W_TW+1)'(step);
		if (sum >= {1'b0, d})
			sum = sum - {1'b0, d};
		return sum[W_TW-1:0];
	endfunction

	// frame start takes the new settings on its own beat
	assign radix_cur = sof ? radix : radix_q;
	assign den_cur   = sof ? den : den_q;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			// idle lanes and k=0 both give twiddle 1
			if (sof || i >= int'(radix_cur))
				num_cur[i] = '0;
			else
				num_cur[i] = acc[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			radix_q <= RADIX_2;
			den_q   <= '0;
			for (int i = 0; i < NUM_LANES; i++)
				acc[i] <= '0;
		end else if (in_val) begin
			if (sof) begin
				radix_q <= radix;
				den_q   <= den;
			end
			for (int i = 0; i < NUM_LANES; i++)
				acc[i] <= next_acc(sof ? '0 : acc[i], i, den_cur);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx <= '0;
		end else begin
			idx.valid <= in_val;
			idx.den   <= den_cur;
			idx.num   <= num_cur;
		end
	end

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_chk
		assert property (@(posedge clk) disable iff (!rst_n)
			idx.valid |-> idx.num[g] < idx.den);
	end

endmodule

//--- design/twdl_phase_divider.sv
`timescale 1ns/100ps

module twdl_phase_divider import twdl_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [W_TW-1:0]    num,
	input  logic [W_TW-1:0]    den,
	output logic [W_PHASE-1:0] phase
);

	// remainder and divisor ride along with the partial quotient
	logic [W_TW-1:0]    rem_q [W_PHASE-1];
	logic [W_TW-1:0]    den_q [W_PHASE-1];
	logic [W_PHASE-1:0] quo_q [W_PHASE];

	// one restoring step, returns {quotient bit, remainder}
	function automatic logic [W_TW:0] div_step(input logic [W_TW-1:0] r,
			input logic [W_TW-1:0] d);
		logic [W_TW:0] r2;
		r2 = {r, 1'b0};
		if (r2 >= {1'b0, d})
			return {1'b1, W_TW'(r2 - {1'b0, d})};
		return {1'b0, r2[W_TW-1:0]};
	endfunction

	for (genvar s = 0; s < W_PHASE; s++) begin : g_stage
		logic [W_TW-1:0]    rem_in;
		logic [W_TW-1:0]    den_in;
		logic [W_PHASE-1:0] quo_in;
		logic [W_TW:0]      step;

		if (s == 0) begin : g_first
			assign rem_in = num;
			assign den_in = den;
			assign quo_in = '0;
		end else begin : g_next
			assign rem_in = rem_q[s-1];
			assign den_in = den_q[s-1];
			assign quo_in = quo_q[s-1];
		end

		assign step = div_step(rem_in, den_in);

		always_ff @(posedge clk) begin
			if (!rst_n)
				quo_q[s] <= '0;
			else
				quo_q[s] <= {quo_in[W_PHASE-2:0], step[W_TW]};
		end

		// last stage keeps only the quotient
		if (s < W_PHASE - 1) begin : g_carry
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					rem_q[s] <= '0;
					den_q[s] <= '0;
				end else begin
					rem_q[s] <= step[W_TW-1:0];
					den_q[s] <= den_in;
				end
			end
		end
	end

	assign phase = quo_q[W_PHASE-1];

	// a nonzero index needs a frame denominator behind it
	assert property (@(posedge clk) disable iff (!rst_n) (num != '0) |-> (den != '0));

endmodule

//--- design/twdl_pkg.sv
package twdl_pkg;

	// butterfly lanes per beat
	localparam int NUM_LANES = 5;
	localparam int W_TW      = 12;
	localparam int W_COEF    = 16;
	localparam int COEF_FRAC = 14;
	// 256 points per turn
	localparam int W_PHASE   = 8;

	localparam real PI = 3.14159265358979323846;

	typedef enum logic [2:0] {
		RADIX_2 = 3'd2,
		RADIX_3 = 3'd3,
		RADIX_4 = 3'd4,
		RADIX_5 = 3'd5
	} radix_e;

	typedef struct packed {
		logic signed [W_COEF-1:0] re;
		logic signed [W_COEF-1:0] im;
	} tw_coef_t;

	typedef struct packed {
		logic                           valid;
		logic [W_TW-1:0]                den;
		logic [NUM_LANES-1:0][W_TW-1:0] num;
	} tw_index_t;

	// cos(2*pi*p/256) scaled by 2^14, rounded half up
	function automatic logic signed [W_COEF-1:0] cos_q14(input logic [W_PHASE-1:0] p);
		real ang;
		real val;
		ang = 2.0 * PI * real'(p) / real'(1 << W_PHASE);
		val = $cos(ang) * real'(1 << COEF_FRAC);
		return W_COEF'($rtoi($floor(val + 0.5)));
	endfunction

endpackage

//--- design/twdl_stage.sv
`timescale 1ns/100ps

module twdl_stage import twdl_pkg::*; #(
	parameter int W_DATA = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_val,
	input  logic                     sof,
	input  radix_e                   radix,
	input  logic [W_TW-1:0]          den,
	input  logic signed [W_DATA-1:0] din_real [NUM_LANES],
	input  logic signed [W_DATA-1:0] din_imag [NUM_LANES],
	output logic                     out_val,
	output logic signed [W_DATA-1:0] dout_real [NUM_LANES],
	output logic signed [W_DATA-1:0] dout_imag [NUM_LANES]
);

	// counter + divider + table
	localparam int DELAY   = 10;
	// plus multiply and rounding
	localparam int LATENCY = DELAY + 2;

	tw_index_t          idx;
	tw_coef_t           coef [NUM_LANES];
	logic               coef_val;
	logic [LATENCY-1:0] val_sr;

	twdl_phase_counter i_counter (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_val (in_val),
		.sof    (sof),
		.radix  (radix),
		.den    (den),
		.idx    (idx)
	);

	twdl_coeff_gen i_coeff (
		.clk      (clk),
		.rst_n    (rst_n),
		.idx      (idx),
		.coef     (coef),
		.coef_val (coef_val)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		twdl_lane_multiplier #(
			.W_DATA (W_DATA),
			.DELAY  (DELAY)
		) i_mult (
			.clk       (clk),
			.rst_n     (rst_n),
			.din_real  (din_real[i]),
			.din_imag  (din_imag[i]),
			.coef      (coef[i]),
			.dout_real (dout_real[i]),
			.dout_imag (dout_imag[i])
		);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			val_sr <= '0;
		else
			val_sr <= {val_sr[LATENCY-2:0], in_val};
	end

	assign out_val = val_sr[LATENCY-1];

	assert property (@(posedge clk) disable iff (!rst_n) sof |-> in_val);

	// coefficients meet the delayed samples on the same cycle
	assert property (@(posedge clk) disable iff (!rst_n) coef_val == val_sr[DELAY-1]);

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam real HALF_PERIOD  = 4.0;
	localparam int  RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- testbench/tb_twdl_stage.sv
`timescale 1ns/100ps

module tb_twdl_stage import twdl_pkg::*; ();

	localparam int  W_DATA      = 30;
	localparam int  W_SAMP      = 28;
	localparam int  LATENCY     = 12;
	localparam int  RESET_LIMIT = 100;
	localparam int  DRAIN_LIMIT = 200;
	localparam real PI_REF      = 3.14159265358979323846;

	// one accepted beat as the model sees it
	typedef struct packed {
		logic [NUM_LANES-1:0][W_DATA-1:0] re;
		logic [NUM_LANES-1:0][W_DATA-1:0] im;
		logic [W_TW-1:0]                  den;
		logic [2:0]                       radix;
		logic [15:0]                      k;
		logic [31:0]                      cyc;
	} beat_t;

	logic                     clk;
	logic                     rst_n;
	logic                     in_val;
	logic                     sof;
	radix_e                   radix;
	logic [W_TW-1:0]          den;
	logic signed [W_DATA-1:0] din_real [NUM_LANES];
	logic signed [W_DATA-1:0] din_imag [NUM_LANES];
	logic                     out_val;
	logic signed [W_DATA-1:0] dout_real [NUM_LANES];
	logic signed [W_DATA-1:0] dout_imag [NUM_LANES];

	beat_t       expected [$];
	int          errors   = 0;
	int          timeouts = 0;
	int          cyc      = 0;
	logic [15:0] lfsr_state = 16'd80;

	tb_clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	twdl_stage #(
		.W_DATA (W_DATA)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val    (in_val),
		.sof       (sof),
		.radix     (radix),
		.den       (den),
		.din_real  (din_real),
		.din_imag  (din_imag),
		.out_val   (out_val),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	always @(posedge clk)
		cyc <= cyc + 1;

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int b = 0; b < n; b++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic signed [W_DATA-1:0] rand_sample();
		logic [W_SAMP-1:0] r;
		r = rand_bits(W_SAMP);
		return {{(W_DATA-W_SAMP){r[W_SAMP-1]}}, r};
	endfunction

	function automatic longint cos_model(input int p);
		real a;
		a = 2.0 * PI_REF * real'(p) / 256.0;
		return longint'($rtoi($floor($cos(a) * 16384.0 + 0.5)));
	endfunction

	function automatic void ref_twiddle(input int lane, input int k, input int n, input int rdx,
			input longint xr, input longint xi, output longint yr, output longint yi);
		int     tw_idx;
		int     phase;
		longint cr;
		longint ci;
		longint pr;
		longint pim;
		tw_idx = (lane >= rdx) ? 0 : (lane * k) % n;
		phase  = (tw_idx * 256) / n;
		cr     = cos_model(phase);
		// -sin as minus the cosine a quarter turn back
		ci     = -cos_model((phase + 192) % 256);
		pr     = xr * cr - xi * ci;
		pim    = xr * ci + xi * cr;
		yr     = (pr + 8192) >>> 14;
		yi     = (pim + 8192) >>> 14;
	endfunction

	task automatic check_beat(input beat_t b);
		logic signed [W_DATA-1:0] xr;
		logic signed [W_DATA-1:0] xi;
		longint                   yr;
		longint                   yi;
		assert (cyc - b.cyc == LATENCY) else begin
			$display("ERR %0t: latency %0d cycles, expected %0d", $time, cyc - b.cyc, LATENCY);
			errors++;
		end
		for (int i = 0; i < NUM_LANES; i++) begin
			xr = b.re[i];
			xi = b.im[i];
			ref_twiddle(i, b.k, b.den, b.radix, xr, xi, yr, yi);
			assert (dout_real[i] == W_DATA'(yr)) else begin
				$display("ERR %0t: lane %0d real %0d, expected %0d (k=%0d N=%0d)",
					$time, i, dout_real[i], W_DATA'(yr), b.k, b.den);
				errors++;
			end
			assert (dout_imag[i] == W_DATA'(yi)) else begin
				$display("ERR %0t: lane %0d imag %0d, expected %0d (k=%0d N=%0d)",
					$time, i, dout_imag[i], W_DATA'(yi), b.k, b.den);
				errors++;
			end
			// idle lanes pass the sample through
			if (i >= b.radix)
				assert (dout_real[i] == xr && dout_imag[i] == xi) else begin
					$display("ERR %0t: idle lane %0d changed the sample", $time, i);
					errors++;
				end
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int c = 0; c < n; c++) begin
			@(negedge clk);
			in_val = 1'b0;
			sof    = 1'b0;
		end
	endtask

	task automatic drive_beat(input logic start, input radix_e rdx, input int n, input int k);
		beat_t b;
		@(negedge clk);
		in_val = 1'b1;
		sof    = start;
		// settings off the frame start must be ignored
		radix  = start ? rdx : radix_e'(3'(2 + rand_bits(2)));
		den    = start ? W_TW'(n) : W_TW'(rand_bits(W_TW));
		for (int i = 0; i < NUM_LANES; i++) begin
			din_real[i] = rand_sample();
			din_imag[i] = rand_sample();
			b.re[i]     = din_real[i];
			b.im[i]     = din_imag[i];
		end
		b.den   = W_TW'(n);
		b.radix = 3'(rdx);
		b.k     = 16'(k);
		b.cyc   = cyc;
		expected.push_back(b);
	endtask

	task automatic run_frame(input radix_e rdx, input int n, input int beats, input logic gappy);
		for (int k = 0; k < beats; k++) begin
			drive_beat(k == 0, rdx, n, k);
			if (gappy && rand_bits(2) == 0)
				idle_cycles(1 + rand_bits(2));
		end
	endtask

	initial begin : compare_outputs
		beat_t b;
		forever begin
			@(negedge clk);
			if (out_val === 1'b1) begin
				assert (expected.size() != 0) else begin
					$display("ERR %0t: out_val high with no beat in flight", $time);
					errors++;
				end
				if (expected.size() != 0) begin
					b = expected.pop_front();
					check_beat(b);
				end
			end else if (expected.size() != 0 && cyc - expected[0].cyc > LATENCY) begin
				$display("timeout waiting for the output of the beat sent at cycle %0d",
					expected[0].cyc);
				timeouts++;
				void'(expected.pop_front());
			end
		end
	end

	initial begin : stimulus
		int wait_cnt;
		in_val = 1'b0;
		sof    = 1'b0;
		radix  = RADIX_2;
		den    = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			din_real[i] = '0;
			din_imag[i] = '0;
		end
		wait_cnt = 0;
		while (rst_n !== 1'b1 && wait_cnt < RESET_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout waiting for reset to be released");
			timeouts++;
		end else begin
			idle_cycles(10);
			run_frame(RADIX_5, 60, 60, 1'b1);
			run_frame(RADIX_2, 20, 25, 1'b1);
			run_frame(RADIX_3, 21, 25, 1'b1);
			run_frame(RADIX_4, 24, 30, 1'b1);
			// restart before the frame completes
			run_frame(RADIX_5, 60, 23, 1'b1);
			run_frame(RADIX_5, 60, 40, 1'b1);
			// back to back so old beats are still in flight
			run_frame(RADIX_4, 16, 20, 1'b0);
			run_frame(RADIX_5, 45, 50, 1'b0);
			idle_cycles(1);
			wait_cnt = 0;
			while (expected.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (expected.size() != 0) begin
				$display("timeout waiting for %0d outstanding outputs", expected.size());
				timeouts++;
			end
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
